//--- design/mrelbp_pkg.sv
package mrelbp_pkg;

  // ##############################
  // geometry
  // ##############################

  localparam int COLS          = 16;  // columns per row
  localparam int MAX_RADIUS    = 4;   // column height 9, center delay 4
  localparam int NUM_RADII     = 4;
  localparam int CODES_PER_ROW = COLS - 2 * MAX_RADIUS;

  localparam int COL_CNT_W  = $clog2(COLS);
  localparam int CODE_CNT_W = $clog2(CODES_PER_ROW);

  // ##############################
  // data widths
  // ##############################

  typedef logic [7:0]  pix_t;
  typedef logic [11:0] col_sum_t;  // up to nine pixels
  typedef logic [14:0] win_sum_t;  // up to 81 pixels, also pixel * area

  // one CI bit per radius, bit r-1 for radius r
  typedef logic [NUM_RADII-1:0] ci_code_t;

endpackage

//--- design/ci_column_feeder.sv
`timescale 1ns/1ps

module ci_column_feeder (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 col_valid,
  input  mrelbp_pkg::pix_t     pix0,
  input  mrelbp_pkg::pix_t     pix1,
  input  mrelbp_pkg::pix_t     pix2,
  input  mrelbp_pkg::pix_t     pix3,
  input  mrelbp_pkg::pix_t     pix4,
  input  mrelbp_pkg::pix_t     pix5,
  input  mrelbp_pkg::pix_t     pix6,
  input  mrelbp_pkg::pix_t     pix7,
  input  mrelbp_pkg::pix_t     pix8,
  output mrelbp_pkg::col_sum_t col_sum_r1,
  output mrelbp_pkg::col_sum_t col_sum_r2,
  output mrelbp_pkg::col_sum_t col_sum_r3,
  output mrelbp_pkg::col_sum_t col_sum_r4,
  output mrelbp_pkg::pix_t     center_pix,
  output logic                 sum_valid,
  output logic                 row_first,
  output logic                 win_full
);
  import mrelbp_pkg::*;

  col_sum_t             sum_r1;
  col_sum_t             sum_r2;
  col_sum_t             sum_r3;
  col_sum_t             sum_r4;
  pix_t                 center_dl [MAX_RADIUS];
  logic [COL_CNT_W-1:0] col_cnt;

  // nested groups around pix4
  assign sum_r1 = col_sum_t'(pix3) + col_sum_t'(pix4) + col_sum_t'(pix5);
  assign sum_r2 = sum_r1 + col_sum_t'(pix2) + col_sum_t'(pix6);
  assign sum_r3 = sum_r2 + col_sum_t'(pix1) + col_sum_t'(pix7);
  assign sum_r4 = sum_r3 + col_sum_t'(pix0) + col_sum_t'(pix8);

  // ##############################
  // column counter, center delay
  // ##############################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sum_valid <= 1'b0;
      row_first <= 1'b0;
      win_full  <= 1'b0;
      col_cnt   <= '0;
      for (int i = 0; i < MAX_RADIUS; i++) begin
        center_dl[i] <= '0;
      end
    end else begin
      sum_valid <= col_valid;
      if (col_valid) begin
        row_first <= (col_cnt == '0);
        win_full  <= (col_cnt >= COL_CNT_W'(2 * MAX_RADIUS));  // ninth column on
        col_cnt   <= (col_cnt == COL_CNT_W'(COLS - 1)) ? '0 : col_cnt + 1'b1;
        center_dl[0] <= pix4;
        for (int i = 1; i < MAX_RADIUS; i++) begin
          center_dl[i] <= center_dl[i-1];
        end
      end
    end
  end

  // per-column payload
  always_ff @(posedge clk) begin
    if (col_valid) begin
      col_sum_r1 <= sum_r1;
      col_sum_r2 <= sum_r2;
      col_sum_r3 <= sum_r3;
      col_sum_r4 <= sum_r4;
      center_pix <= center_dl[MAX_RADIUS-1];  // four columns back
    end
  end

endmodule

//--- design/ci_radius_lane.sv
`timescale 1ns/1ps

module ci_radius_lane #(
  parameter int RADIUS = 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mrelbp_pkg::col_sum_t col_sum,
  input  mrelbp_pkg::pix_t     center_pix,
  input  logic                 sum_valid,
  input  logic                 row_first,
  input  logic                 win_full,
  output logic                 ci_bit,
  output logic                 bit_valid
);
  import mrelbp_pkg::*;

  // window spans delays ADD_TAP..SUB_TAP-1, centered on delay MAX_RADIUS
  localparam int       ADD_TAP    = MAX_RADIUS - RADIUS;
  localparam int       SUB_TAP    = MAX_RADIUS + RADIUS + 1;
  localparam int       LINE_DEPTH = SUB_TAP;  // line[k-1] holds delay k
  localparam win_sum_t AREA       = win_sum_t'((2 * RADIUS + 1) * (2 * RADIUS + 1));

  col_sum_t line [LINE_DEPTH];
  col_sum_t add_sum;
  col_sum_t sub_sum;
  win_sum_t run_sum;
  win_sum_t scaled;
  pix_t     center_q;
  logic     cmp_pend;

  generate
    if (ADD_TAP == 0) begin : g_add_in
      assign add_sum = col_sum;  // widest lane takes the new column directly
    end else begin : g_add_line
      assign add_sum = line[ADD_TAP-1];
    end
  endgenerate

  assign sub_sum = line[SUB_TAP-1];
  assign scaled  = win_sum_t'(center_q) * AREA;

  // ##############################
  // stage 1: line and running sum
  // ##############################

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < LINE_DEPTH; i++) begin
        line[i] <= '0;
      end
      run_sum   <= '0;
      cmp_pend  <= 1'b0;
      bit_valid <= 1'b0;
    end else begin
      cmp_pend  <= sum_valid & win_full;
      bit_valid <= cmp_pend;
      if (sum_valid) begin
        line[0] <= col_sum;
        for (int i = 1; i < LINE_DEPTH; i++) begin
          line[i] <= row_first ? '0 : line[i-1];  // new row drops old columns
        end
        if (row_first) begin
          run_sum <= (ADD_TAP == 0) ? win_sum_t'(col_sum) : '0;
        end else begin
          run_sum <= run_sum + win_sum_t'(add_sum) - win_sum_t'(sub_sum);
        end
      end
    end
  end

  // stage 2: center * area vs window sum, ties give 1
  always_ff @(posedge clk) begin
    if (sum_valid) begin
      center_q <= center_pix;
    end
    if (cmp_pend) begin
      ci_bit <= (scaled < run_sum) ? 1'b0 : 1'b1;
    end
  end

endmodule

//--- design/ci_code_packer.sv
`timescale 1ns/1ps

module ci_code_packer (
  input  logic                 clk,
  input  logic                 rst_n,
  input  mrelbp_pkg::ci_code_t ci_bits,
  input  logic                 bit_valid,
  output mrelbp_pkg::ci_code_t ci_code,
  output logic                 code_valid,
  output logic                 row_done
);
  import mrelbp_pkg::*;

  logic [CODE_CNT_W-1:0] code_cnt;
  logic                  last_code;

  assign last_code = (code_cnt == CODE_CNT_W'(CODES_PER_ROW - 1));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      code_valid <= 1'b0;
      row_done   <= 1'b0;
      code_cnt   <= '0;
    end else begin
      code_valid <= bit_valid;
      row_done   <= bit_valid & last_code;  // last code of the row
      if (bit_valid) begin
        code_cnt <= last_code ? '0 : code_cnt + 1'b1;
      end
    end
  end

  // held until the next code
  always_ff @(posedge clk) begin
    if (bit_valid) begin
      ci_code <= ci_bits;
    end
  end

endmodule

//--- design/mrelbp_ci_top.sv
`timescale 1ns/1ps

module mrelbp_ci_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 col_valid,
  input  mrelbp_pkg::pix_t     pix0,
  input  mrelbp_pkg::pix_t     pix1,
  input  mrelbp_pkg::pix_t     pix2,
  input  mrelbp_pkg::pix_t     pix3,
  input  mrelbp_pkg::pix_t     pix4,
  input  mrelbp_pkg::pix_t     pix5,
  input  mrelbp_pkg::pix_t     pix6,
  input  mrelbp_pkg::pix_t     pix7,
  input  mrelbp_pkg::pix_t     pix8,
  output mrelbp_pkg::ci_code_t ci_code,
  output logic                 code_valid,
  output logic                 row_done
);
  import mrelbp_pkg::*;

  col_sum_t col_sum_r1;
  col_sum_t col_sum_r2;
  col_sum_t col_sum_r3;
  col_sum_t col_sum_r4;
  col_sum_t lane_sum [NUM_RADII];
  pix_t     center_pix;
  logic     sum_valid;
  logic     row_first;
  logic     win_full;
  ci_code_t lane_bits;
  logic     bits_valid;

  ci_column_feeder i_feeder (
    .clk        (clk),
    .rst_n      (rst_n),
    .col_valid  (col_valid),
    .pix0       (pix0),
    .pix1       (pix1),
    .pix2       (pix2),
    .pix3       (pix3),
    .pix4       (pix4),
    .pix5       (pix5),
    .pix6       (pix6),
    .pix7       (pix7),
    .pix8       (pix8),
    .col_sum_r1 (col_sum_r1),
    .col_sum_r2 (col_sum_r2),
    .col_sum_r3 (col_sum_r3),
    .col_sum_r4 (col_sum_r4),
    .center_pix (center_pix),
    .sum_valid  (sum_valid),
    .row_first  (row_first),
    .win_full   (win_full)
  );

  assign lane_sum[0] = col_sum_r1;
  assign lane_sum[1] = col_sum_r2;
  assign lane_sum[2] = col_sum_r3;
  assign lane_sum[3] = col_sum_r4;

  // ##############################
  // radius lanes
  // ##############################

  for (genvar i = 0; i < NUM_RADII; i++) begin : g_lane
    if (i == 0) begin : g_timed  // lanes run in lockstep, one valid is enough
      ci_radius_lane #(.RADIUS(i + 1)) i_lane (
        .clk        (clk),
        .rst_n      (rst_n),
        .col_sum    (lane_sum[i]),
        .center_pix (center_pix),
        .sum_valid  (sum_valid),
        .row_first  (row_first),
        .win_full   (win_full),
        .ci_bit     (lane_bits[i]),
        .bit_valid  (bits_valid)
      );
    end else begin : g_plain
      ci_radius_lane #(.RADIUS(i + 1)) i_lane (
        .clk        (clk),
        .rst_n      (rst_n),
        .col_sum    (lane_sum[i]),
        .center_pix (center_pix),
        .sum_valid  (sum_valid),
        .row_first  (row_first),
        .win_full   (win_full),
        .ci_bit     (lane_bits[i]),
        .bit_valid  ()
      );
    end
  end

  ci_code_packer i_packer (
    .clk        (clk),
    .rst_n      (rst_n),
    .ci_bits    (lane_bits),
    .bit_valid  (bits_valid),
    .ci_code    (ci_code),
    .code_valid (code_valid),
    .row_done   (row_done)
  );

endmodule

//--- verif/mrelbp_ci_assert.sv
`timescale 1ns/1ps

module mrelbp_ci_assert (
  input logic clk,
  input logic rst_n,
  input logic col_valid,
  input logic code_valid,
  input logic row_done
);
  import mrelbp_pkg::*;

  logic [COL_CNT_W-1:0] col_cnt;
  logic                 completes;

  // ninth column of a row onward closes a window
  assign completes = col_valid && (col_cnt >= COL_CNT_W'(2 * MAX_RADIUS));

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      col_cnt <= '0;
    end else if (col_valid) begin
      col_cnt <= (col_cnt == COL_CNT_W'(COLS - 1)) ? '0 : col_cnt + 1'b1;
    end
  end

  a_code_latency: assert property (@(posedge clk) disable iff (!rst_n)
    completes |-> ##4 code_valid)
    else $error("code_valid missing 4 cycles after a completing column");

  a_row_done_with_code: assert property (@(posedge clk) disable iff (!rst_n)
    row_done |-> code_valid)
    else $error("row_done raised without code_valid");

  a_quiet_in_reset: assert property (@(posedge clk) !rst_n |=> !code_valid)
    else $error("code_valid raised during reset");

endmodule

bind mrelbp_ci_top mrelbp_ci_assert i_assert (.*);

//--- verif/mrelbp_ci_tb.sv
`timescale 1ns/1ps

module mrelbp_ci_tb;
  import mrelbp_pkg::*;

  localparam int NUM_ROWS    = 10;
  localparam int DRAIN_LIMIT = 200;
  localparam int SPIKE_COL   = 8;
  localparam int KINK_COL    = 7;

  localparam logic [1:0] K_CONST = 2'd0;
  localparam logic [1:0] K_RAMP  = 2'd1;
  localparam logic [1:0] K_SPIKE = 2'd2;
  localparam logic [1:0] K_RAND  = 2'd3;

  typedef struct packed {
    logic [1:0] kind;
    logic       gap;    // idle cycle after each column
    pix_t       base;
    logic       fixed;  // whole row has one known code
    ci_code_t   code;
  } row_spec_t;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        col_valid;
  pix_t        pix_in [9];
  ci_code_t    ci_code;
  logic        code_valid;
  logic        row_done;
  row_spec_t   row_tbl [NUM_ROWS];
  pix_t        img [NUM_ROWS][COLS][9];
  ci_code_t    exp_code_q [$];
  logic        exp_last_q [$];
  logic [31:0] lcg_state = 32'd34438;
  int          err_cnt = 0;

  always #2 clk = ~clk;

  mrelbp_ci_top i_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .col_valid  (col_valid),
    .pix0       (pix_in[0]),
    .pix1       (pix_in[1]),
    .pix2       (pix_in[2]),
    .pix3       (pix_in[3]),
    .pix4       (pix_in[4]),
    .pix5       (pix_in[5]),
    .pix6       (pix_in[6]),
    .pix7       (pix_in[7]),
    .pix8       (pix_in[8]),
    .ci_code    (ci_code),
    .code_valid (code_valid),
    .row_done   (row_done)
  );

  function automatic pix_t next_rand_pix();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state[23:16];
  endfunction

  function automatic void fill_row(input int ri);
    int v;
    for (int c = 0; c < COLS; c++) begin
      for (int y = 0; y < 9; y++) begin
        case (row_tbl[ri].kind)
          K_CONST: v = int'(row_tbl[ri].base);
          K_RAMP:  v = (c < KINK_COL) ? int'(row_tbl[ri].base) :
                       int'(row_tbl[ri].base) + 16 * (c - KINK_COL);  // convex kink
          K_SPIKE: v = (c == SPIKE_COL && y == 4) ? 255 : int'(row_tbl[ri].base);
          default: v = int'(next_rand_pix());
        endcase
        img[ri][c][y] = pix_t'(v);
      end
    end
  endfunction

  // center * area >= window sum per radius
  function automatic ci_code_t model_code(input int ri, input int ctr);
    ci_code_t code;
    int       sum;
    int       area;
    for (int r = 1; r <= MAX_RADIUS; r++) begin
      sum  = 0;
      area = (2 * r + 1) * (2 * r + 1);
      for (int x = ctr - r; x <= ctr + r; x++) begin
        for (int y = MAX_RADIUS - r; y <= MAX_RADIUS + r; y++) begin
          sum += int'(img[ri][x][y]);
        end
      end
      code[r-1] = (int'(img[ri][ctr][MAX_RADIUS]) * area >= sum);
    end
    return code;
  endfunction

  function automatic void queue_expected(input int ri);
    for (int ctr = MAX_RADIUS; ctr < COLS - MAX_RADIUS; ctr++) begin
      if (row_tbl[ri].fixed) begin
        exp_code_q.push_back(row_tbl[ri].code);
      end else begin
        exp_code_q.push_back(model_code(ri, ctr));
      end
      exp_last_q.push_back(ctr == COLS - MAX_RADIUS - 1);
    end
  endfunction

  task automatic send_row(input int ri);
    for (int c = 0; c < COLS; c++) begin
      @(posedge clk);
      col_valid <= 1'b1;
      for (int y = 0; y < 9; y++) begin
        pix_in[y] <= img[ri][c][y];
      end
      if (row_tbl[ri].gap) begin
        @(posedge clk);
        col_valid <= 1'b0;
        for (int y = 0; y < 9; y++) begin
          pix_in[y] <= next_rand_pix();  // junk while idle
        end
      end
    end
  endtask

  task automatic check_value(input int got, input int exp, input string what);
    if (got != exp) begin
      err_cnt++;
      $display("error at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
      $display("Errors found");
      $fatal(1, "%s mismatch", what);
    end
  endtask

  // ##############################
  // monitor
  // ##############################

  always @(posedge clk) begin
    if (rst_n && code_valid) begin
      if (exp_code_q.size() == 0) begin
        $display("a code arrived at %0d ns while none was expected", $time);
        $display("Errors found");
        $fatal(1, "unexpected code");
      end else begin
        check_value(int'(ci_code), int'(exp_code_q.pop_front()), "ci_code");
        check_value(int'(row_done), int'(exp_last_q.pop_front()), "row_done");
      end
    end
  end

  initial begin
    int wait_cnt;
    rst_n     = 1'b0;
    col_valid = 1'b0;
    for (int y = 0; y < 9; y++) begin
      pix_in[y] = '0;
    end
    row_tbl[0] = '{K_CONST, 1'b0, 8'd100, 1'b1, 4'hf};
    row_tbl[1] = '{K_CONST, 1'b1, 8'd0,   1'b1, 4'hf};
    row_tbl[2] = '{K_SPIKE, 1'b0, 8'd40,  1'b0, 4'h0};
    row_tbl[3] = '{K_RAMP,  1'b0, 8'd20,  1'b0, 4'h0};
    row_tbl[4] = '{K_RAMP,  1'b1, 8'd100, 1'b0, 4'h0};
    row_tbl[5] = '{K_RAND,  1'b0, 8'd0,   1'b0, 4'h0};
    row_tbl[6] = '{K_RAND,  1'b1, 8'd0,   1'b0, 4'h0};
    row_tbl[7] = '{K_RAND,  1'b0, 8'd0,   1'b0, 4'h0};
    row_tbl[8] = '{K_SPIKE, 1'b1, 8'd200, 1'b0, 4'h0};
    row_tbl[9] = '{K_CONST, 1'b0, 8'd255, 1'b1, 4'hf};
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;

    // ##############################
    // rows from the table
    // ##############################
    for (int ri = 0; ri < NUM_ROWS; ri++) begin
      fill_row(ri);
      queue_expected(ri);
      send_row(ri);
    end
    @(posedge clk);
    col_valid <= 1'b0;

    wait_cnt = 0;
    while (exp_code_q.size() != 0 && wait_cnt < DRAIN_LIMIT) begin
      @(posedge clk);
      wait_cnt++;
    end
    if (exp_code_q.size() != 0) begin
      $display("timeout: %0d expected codes never came out", exp_code_q.size());
      $display("Errors found");
      $fatal(1, "drain timeout");
    end
    repeat (10) @(posedge clk);  // no stray codes after the last row

    if (err_cnt == 0) begin
      $display("No errors");
      $finish;
    end else begin
      $display("Errors found");
      $fatal(1, "checks failed");
    end
  end

endmodule

//--- tb.f
design/mrelbp_pkg.sv
design/ci_column_feeder.sv
design/ci_radius_lane.sv
design/ci_code_packer.sv
design/mrelbp_ci_top.sv
verif/mrelbp_ci_assert.sv
verif/mrelbp_ci_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert
TOP      = mrelbp_ci_tb
FILELIST = tb.f
OBJ_DIR  = obj_dir

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
